//--- source/ring_cfg_pkg.sv
/*
 * Ring geometry package
 * Slot count, push lane count and byte width of the byte ring
 */

package ring_cfg_pkg;

  // ----------------------------------------------------------------------
  // Ring geometry
  // ----------------------------------------------------------------------

  // Number of byte slots; not a power of two, so pointers wrap explicitly
  localparam int ring_depth = 12;

  // Largest number of bytes a single push may carry
  localparam int push_lanes = 4;

  // Width of one data byte
  localparam int byte_width = 8;

endpackage : ring_cfg_pkg

//--- source/ring_types_pkg.sv
/*
 * Ring type package
 * Pointer, level, lane count, byte and push word types sized from the geometry
 */

package ring_types_pkg;

  import ring_cfg_pkg::*;

  // Field widths derived from the geometry
  localparam int ptr_width      = $clog2(ring_depth);
  localparam int level_width    = $clog2(ring_depth + 1);
  localparam int lane_cnt_width = $clog2(push_lanes + 1);

  typedef logic [ptr_width-1:0]      ptr_t;
  typedef logic [level_width-1:0]    level_t;
  typedef logic [lane_cnt_width-1:0] lane_cnt_t;
  typedef logic [byte_width-1:0]     byte_t;

  // Lane 0 sits in the least significant byte
  typedef byte_t [push_lanes-1:0] push_word_t;

endpackage : ring_types_pkg

//--- source/ptr_if.sv
/*
 * Pointer counter interface
 * Increment request toward one counter and the counter's current and next value
 */

`timescale 1ns/1ps

interface ptr_if import ring_types_pkg::*; ();

  // Single-cycle strobe, the increment commits in the cycle it is high
  logic      incr_valid;
  lane_cnt_t incr;
  ptr_t      value;
  ptr_t      value_next;

  // Port module asking for the pointer to move
  modport requester (output incr_valid, output incr, input value);

  // The counter itself
  modport counter (input incr_valid, input incr, output value, output value_next);

  // Storage watches everything and drives nothing
  modport observer (input incr_valid, input incr, input value, input value_next);

endinterface : ptr_if

//--- source/counter_incr.sv
/*
 * Wrapping counter with a variable increment
 * Registered value plus a combinational value_next for same-cycle users
 */

`timescale 1ns/1ps

module counter_incr import ring_cfg_pkg::*, ring_types_pkg::*; #(
  parameter int modulus  = ring_depth,
  parameter int max_incr = push_lanes
) (
  input logic clk,
  input logic reset,
  ptr_if.counter ptr
);

  // One extra bit holds value plus incr before the wrap
  logic [ptr_width:0] sum;
  ptr_t               value_wrapped;

  // ----------------------------------------------------------------------
  // Next value
  // ----------------------------------------------------------------------

  assign sum = {1'b0, ptr.value} + (ptr_width + 1)'(ptr.incr);

  if ((modulus & (modulus - 1)) == 0) begin : g_pow2
    // Power of two, so dropping the upper bits is the wrap
    assign value_wrapped = ptr_t'(sum & (modulus - 1));
  end else begin : g_explicit_wrap
    // A single subtract is enough since value and incr each stay below modulus
    assign value_wrapped = (sum >= modulus) ? ptr_t'(sum - modulus) : ptr_t'(sum);
  end

  // Holds the current value when no increment is requested
  assign ptr.value_next = ptr.incr_valid ? value_wrapped : ptr.value;

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr.value <= '0;
    end else begin
      ptr.value <= ptr.value_next;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The requesting port must respect the counter's step limit
  assert property (@(posedge clk) disable iff (reset)
    ptr.incr_valid |-> ptr.incr <= max_incr);

  // Pointer never lands outside the ring
  assert property (@(posedge clk) disable iff (reset)
    ptr.value < modulus);

  // Each committed step moves the pointer by incr around the ring
  assert property (@(posedge clk) disable iff (reset)
    !$past(reset) && $past(ptr.incr_valid) |->
      int'(ptr.value) == (int'($past(ptr.value)) + int'($past(ptr.incr))) % modulus);

endmodule : counter_incr

//--- source/ring_write_port.sv
/*
 * Push side of the byte ring
 * Four-phase req/ack handshake, free space check and write pointer advance
 */

`timescale 1ns/1ps

module ring_write_port import ring_cfg_pkg::*, ring_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      push_req,
  input  lane_cnt_t push_count,
  output logic      push_ack,
  input  level_t    level,
  ptr_if.requester  wr_ptr,
  output logic      wr_strobe
);

  // Handshake FSM state, low is idle and high is acked
  logic   acked;
  // Free slots left in the ring
  level_t space;
  // Push is taken this cycle
  logic   commit;

  // ----------------------------------------------------------------------
  // Commit decision
  // ----------------------------------------------------------------------

  assign space = level_t'(ring_depth) - level;

  // A new request is only taken while idle and once the whole push fits
  assign commit = push_req && !acked && (space >= level_t'(push_count));

  // One-cycle increment of the write pointer by the pushed byte count
  assign wr_ptr.incr_valid = commit;
  assign wr_ptr.incr       = push_count;

  // Storage writes the lanes in the same cycle the pointer commits
  assign wr_strobe = commit;

  // ----------------------------------------------------------------------
  // Handshake FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acked <= 1'b0;
    end else if (!acked) begin
      // Idle, wait here while the ring is short of space
      acked <= commit;
    end else begin
      // Acked, return to idle once the producer drops its request
      acked <= push_req;
    end
  end

  // Ack comes straight from the state flop
  assign push_ack = acked;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The producer holds a legal byte count for the whole request
  assert property (@(posedge clk) disable iff (reset)
    push_req |-> (push_count >= 1) && (push_count <= push_lanes));

endmodule : ring_write_port

//--- source/ring_read_port.sv
/*
 * Pop side of the byte ring
 * Four-phase req/ack handshake, empty check, read pointer advance and pop data
 */

`timescale 1ns/1ps

module ring_read_port import ring_cfg_pkg::*, ring_types_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     pop_req,
  output logic     pop_ack,
  output byte_t    pop_data,
  input  level_t   level,
  input  byte_t    head_byte,
  ptr_if.requester rd_ptr
);

  // Handshake FSM state, low is idle and high is acked
  logic acked;
  // Pop is taken this cycle
  logic commit;

  // ----------------------------------------------------------------------
  // Commit decision
  // ----------------------------------------------------------------------

  // An empty ring stalls the request until a push lands
  assign commit = pop_req && !acked && (level != '0);

  // The read pointer always steps by one byte
  assign rd_ptr.incr_valid = commit;
  assign rd_ptr.incr       = lane_cnt_t'(1);

  // ----------------------------------------------------------------------
  // Handshake FSM and data capture
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acked <= 1'b0;
    end else if (!acked) begin
      acked <= commit;
    end else begin
      acked <= pop_req;
    end
  end

  assign pop_ack = acked;

  // head_byte already reflects the slot under the read pointer
  // Stays put while pop_ack is high
  always_ff @(posedge clk) begin
    if (commit) begin
      pop_data <= head_byte;
    end
  end

endmodule : ring_read_port

//--- source/ring_storage.sv
/*
 * Byte storage of the ring
 * Slot array, push lane steering, occupancy level and head byte register
 */

`timescale 1ns/1ps

module ring_storage import ring_cfg_pkg::*, ring_types_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  ptr_if.observer    wr_ptr,
  ptr_if.observer    rd_ptr,
  input  logic       wr_strobe,
  input  push_word_t push_data,
  output level_t     level,
  output byte_t      head_byte
);

  byte_t     mem [ring_depth];
  // Target slot and write enable per push lane
  ptr_t      lane_slot [push_lanes];
  logic      lane_we [push_lanes];
  byte_t     head_src;
  lane_cnt_t pushed;
  lane_cnt_t popped;
  // Slot distance from read to write pointer, for the level check
  ptr_t      ptr_gap;

  // ----------------------------------------------------------------------
  // Lane steering
  // ----------------------------------------------------------------------

  for (genvar l = 0; l < push_lanes; l++) begin : g_lane
    logic [ptr_width:0] slot_sum;
    // Lane l lands l slots past the write pointer, wrapping past the last slot
    assign slot_sum     = {1'b0, wr_ptr.value} + (ptr_width + 1)'(l);
    assign lane_slot[l] = (slot_sum >= ring_depth) ? ptr_t'(slot_sum - ring_depth)
                                                   : ptr_t'(slot_sum);
    // Only the lanes covered by the pushed byte count are written
    assign lane_we[l]   = wr_strobe && (lane_cnt_t'(l) < wr_ptr.incr);
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < push_lanes; l++) begin
      if (lane_we[l]) begin
        mem[lane_slot[l]] <= push_data[l];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Head byte
  // ----------------------------------------------------------------------

  // Read at the next read pointer, so head_byte lines up with the pointer
  // A lane writing that same slot this cycle wins over the stale array entry
  always_comb begin
    head_src = mem[rd_ptr.value_next];
    for (int l = 0; l < push_lanes; l++) begin
      if (lane_we[l] && (lane_slot[l] == rd_ptr.value_next)) begin
        head_src = push_data[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    head_byte <= head_src;
  end

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  assign pushed = wr_strobe ? wr_ptr.incr : '0;
  assign popped = rd_ptr.incr_valid ? rd_ptr.incr : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      level <= '0;
    end else begin
      level <= level + level_t'(pushed) - level_t'(popped);
    end
  end

  assign ptr_gap = (wr_ptr.value >= rd_ptr.value) ? ptr_t'(wr_ptr.value - rd_ptr.value)
                 : ptr_t'(wr_ptr.value + ring_depth - rd_ptr.value);

  // The write port's space check keeps the ring from overfilling
  assert property (@(posedge clk) disable iff (reset) level <= ring_depth);

  // Level agrees with the two counters, a full ring shows a zero gap
  assert property (@(posedge clk) disable iff (reset)
    ptr_gap == ((level == ring_depth) ? ptr_t'(0) : ptr_t'(level)));

endmodule : ring_storage

//--- source/byte_ring_top.sv
/*
 * Byte ring buffer top level
 * Multi-byte push and single-byte pop over req/ack handshakes
 */

`timescale 1ns/1ps

module byte_ring_top import ring_cfg_pkg::*, ring_types_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       push_req,
  input  lane_cnt_t  push_count,
  input  push_word_t push_data,
  output logic       push_ack,
  input  logic       pop_req,
  output logic       pop_ack,
  output byte_t      pop_data,
  output level_t     level
);

  logic  wr_strobe;
  byte_t head_byte;

  ptr_if wr_ptr ();
  ptr_if rd_ptr ();

  // ----------------------------------------------------------------------
  // Pointer counters
  // ----------------------------------------------------------------------

  // Write pointer moves by up to a full push per commit
  counter_incr #(.modulus(ring_depth), .max_incr(push_lanes)) u_wr_counter (
    .clk   (clk),
    .reset (reset),
    .ptr   (wr_ptr)
  );

  // Read pointer moves one byte at a time
  counter_incr #(.modulus(ring_depth), .max_incr(1)) u_rd_counter (
    .clk   (clk),
    .reset (reset),
    .ptr   (rd_ptr)
  );

  // ----------------------------------------------------------------------
  // Ports and storage
  // ----------------------------------------------------------------------

  ring_write_port u_write_port (
    .clk        (clk),
    .reset      (reset),
    .push_req   (push_req),
    .push_count (push_count),
    .push_ack   (push_ack),
    .level      (level),
    .wr_ptr     (wr_ptr),
    .wr_strobe  (wr_strobe)
  );

  ring_read_port u_read_port (
    .clk       (clk),
    .reset     (reset),
    .pop_req   (pop_req),
    .pop_ack   (pop_ack),
    .pop_data  (pop_data),
    .level     (level),
    .head_byte (head_byte),
    .rd_ptr    (rd_ptr)
  );

  // Level leaves through the top port and also feeds both handshakes
  ring_storage u_storage (
    .clk       (clk),
    .reset     (reset),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .wr_strobe (wr_strobe),
    .push_data (push_data),
    .level     (level),
    .head_byte (head_byte)
  );

endmodule : byte_ring_top

//--- tb/byte_ring_tb.sv
/*
 * Testbench for the byte ring buffer
 * Clock, reset, byte queue model, value check and directed push/pop tests
 */

`timescale 1ns/1ps

module byte_ring_tb import ring_cfg_pkg::*; ();

  logic                                 clk;
  logic                                 reset;
  logic                                 push_req;
  logic [$clog2(push_lanes+1)-1:0]      push_count;
  logic [push_lanes*byte_width-1:0]     push_data;
  logic                                 push_ack;
  logic                                 pop_req;
  logic                                 pop_ack;
  logic [byte_width-1:0]                pop_data;
  logic [$clog2(ring_depth+1)-1:0]      level;

  // Reference model, the front of the queue is the next byte to pop
  logic [byte_width-1:0] model_q [$];
  integer seed = 32'h2db9f510;
  string  cur_test;
  int     err_count;
  int     check_count;
  int     test_count;
  int     test_err_start;
  bit     timed_out;

  byte_ring_top u_byte_ring_top (
    .clk        (clk),
    .reset      (reset),
    .push_req   (push_req),
    .push_count (push_count),
    .push_data  (push_data),
    .push_ack   (push_ack),
    .pop_req    (pop_req),
    .pop_ack    (pop_ack),
    .pop_data   (pop_data),
    .level      (level)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A wait that runs out of time ends the run from here
  initial begin
    wait (timed_out);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Check and wait helpers
  // ----------------------------------------------------------------------

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
      err_count++;
    end
  endtask

  // Steps one clock at a time and samples 1 ns after the edge
  task automatic wait_ack(input bit on_push, input logic want, input int limit,
                          output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(posedge clk);
      #1;
      seen = ((on_push ? push_ack : pop_ack) == want);
      n++;
    end
  endtask

  task automatic expect_ack(input bit on_push, input logic want, input string what);
    bit seen;
    wait_ack(on_push, want, 200, seen);
    if (!seen) begin
      $display("Timeout in %s: %s did not happen within 200 cycles", cur_test, what);
      err_count++;
      timed_out = 1'b1;
    end
  endtask

  // ----------------------------------------------------------------------
  // Handshake tasks
  // ----------------------------------------------------------------------

  task automatic push_begin(input int count, input logic [31:0] word);
    push_count = count;
    push_data  = word;
    push_req   = 1'b1;
  endtask

  // Bytes enter the model lane 0 first once the ack is seen
  task automatic push_finish();
    expect_ack(1'b1, 1'b1, "push_ack rise");
    for (int l = 0; l < push_count; l++) begin
      model_q.push_back(push_data[l*byte_width +: byte_width]);
    end
    check("level after push", model_q.size(), level);
    push_req = 1'b0;
    expect_ack(1'b1, 1'b0, "push_ack fall");
  endtask

  task automatic do_push(input int count, input logic [31:0] word);
    push_begin(count, word);
    push_finish();
  endtask

  task automatic pop_finish();
    logic [byte_width-1:0] want;
    expect_ack(1'b0, 1'b1, "pop_ack rise");
    want = model_q.pop_front();
    check("pop_data", want, pop_data);
    check("level after pop", model_q.size(), level);
    pop_req = 1'b0;
    expect_ack(1'b0, 1'b0, "pop_ack fall");
  endtask

  task automatic do_pop();
    pop_req = 1'b1;
    pop_finish();
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = err_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", cur_test, err_count - test_err_start);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------

  task automatic test_single_bytes();
    start_test("single_bytes");
    for (int i = 0; i < 6; i++) begin
      do_push(1, 32'ha0 + i);
    end
    for (int i = 0; i < 6; i++) begin
      do_pop();
    end
    end_test();
  endtask

  // Nine bytes per round move the write pointer across slot eleven
  task automatic test_multi_byte();
    start_test("multi_byte");
    for (int r = 0; r < 4; r++) begin
      do_push(4, 32'h13121110 + (r << 4));
      do_push(3, 32'h00262524 + (r << 4));
      do_push(2, 32'h00003938 + (r << 4));
      for (int i = 0; i < 9; i++) begin
        do_pop();
      end
    end
    end_test();
  endtask

  task automatic test_full_ring();
    bit seen;
    start_test("full_ring");
    for (int i = 0; i < 3; i++) begin
      do_push(4, $random(seed));
    end
    push_begin(2, 32'h0000c3c2);
    wait_ack(1'b1, 1'b1, 20, seen);
    check("push_ack while full", 0, seen);
    // Two pops make room, the waiting push then goes through
    do_pop();
    do_pop();
    push_finish();
    while (model_q.size() > 0) begin
      do_pop();
    end
    end_test();
  endtask

  task automatic test_empty_ring();
    bit seen;
    start_test("empty_ring");
    pop_req = 1'b1;
    wait_ack(1'b0, 1'b1, 20, seen);
    check("pop_ack while empty", 0, seen);
    do_push(1, 32'h0000005a);
    pop_finish();
    end_test();
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    int          space;
    int          cnt;
    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      space = ring_depth - model_q.size();
      if (model_q.size() == 0 || (r[0] && space > 0)) begin
        cnt = r[2:1] + 1;
        if (cnt > space) begin
          cnt = space;
        end
        do_push(cnt, $random(seed));
      end else begin
        do_pop();
      end
    end
    while (model_q.size() > 0) begin
      do_pop();
    end
    end_test();
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    reset      = 1'b1;
    push_req   = 1'b0;
    push_count = '0;
    push_data  = '0;
    pop_req    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_single_bytes();
    test_multi_byte();
    test_full_ring();
    test_empty_ring();
    test_random_mix();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : byte_ring_tb

//--- tb.f
source/ring_cfg_pkg.sv
source/ring_types_pkg.sv
source/ptr_if.sv
source/counter_incr.sv
source/ring_write_port.sv
source/ring_read_port.sv
source/ring_storage.sv
source/byte_ring_top.sv
tb/byte_ring_tb.sv

//--- Makefile
# Verilator build and run of the byte ring testbench

VERILATOR ?= verilator
TOP       ?= byte_ring_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
